//--- rtl/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// First fetch address out of reset
`define CPU_RESET_PC 32'h0000_3000

// Data memory size in words
`define DM_WORDS 1024

// Word index width, addresses bits 11 to 2
`define DM_ADDR_BITS 10

// Register written by jal
`define REG_LINK 5'd31

`endif

//--- rtl/cpuPkg.sv
package cpuPkg;

	//////////////////////////////
	// Vector types
	//////////////////////////////
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;
	typedef logic [5:0]  opcodeT;
	typedef logic [5:0]  funcT;
	typedef logic [2:0]  aluOpT;
	typedef logic [1:0]  regDstT;
	typedef logic [1:0]  wbSelT;
	typedef logic [1:0]  npcSelT;

	// ALU operation codes, bit 2 marks the rotate
	localparam aluOpT ALU_ADD  = 3'd0;
	localparam aluOpT ALU_SUB  = 3'd1;
	localparam aluOpT ALU_OR   = 3'd2;
	localparam aluOpT ALU_ROTL = 3'd4;

	// Destination register select
	localparam regDstT DST_RT = 2'd0;
	localparam regDstT DST_RD = 2'd1;
	localparam regDstT DST_RA = 2'd2;

	// Write-back source select
	localparam wbSelT WB_ALU   = 2'd0;
	localparam wbSelT WB_MEM   = 2'd1;
	localparam wbSelT WB_LINK  = 2'd2;
	localparam wbSelT WB_UPPER = 2'd3;

	// Next pc select
	localparam npcSelT NPC_SEQ    = 2'd0;
	localparam npcSelT NPC_JUMP   = 2'd1;
	localparam npcSelT NPC_BRANCH = 2'd2;
	localparam npcSelT NPC_REG    = 2'd3;

	//////////////////////////////
	// Opcode and funct fields
	//////////////////////////////
	localparam opcodeT OP_RTYPE = 6'h00;
	localparam opcodeT OP_J     = 6'h02;
	localparam opcodeT OP_JAL   = 6'h03;
	localparam opcodeT OP_BEQ   = 6'h04;
	localparam opcodeT OP_ORI   = 6'h0d;
	localparam opcodeT OP_LUI   = 6'h0f;
	localparam opcodeT OP_LW    = 6'h23;
	localparam opcodeT OP_SW    = 6'h2b;
	// Custom rotate, all opcode bits set
	localparam opcodeT OP_ROTL  = 6'h3f;

	localparam funcT FN_JR  = 6'h08;
	localparam funcT FN_ADD = 6'h20;
	localparam funcT FN_SUB = 6'h22;

endpackage

//--- rtl/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
	input  cpuPkg::opcodeT op,
	input  cpuPkg::funcT   func,
	output cpuPkg::regDstT regDst,
	output logic           regWriteEn,
	output logic           signExt,
	output logic           aluSrcImm,
	output cpuPkg::aluOpT  aluOp,
	output logic           memWriteEn,
	output cpuPkg::wbSelT  wbSel,
	output cpuPkg::npcSelT npcSel
);

	logic isRType;
	logic isAdd;
	logic isSub;
	logic isOri;
	logic isLw;
	logic isSw;
	logic isBeq;
	logic isLui;
	logic isJal;
	logic isJr;
	logic isJ;
	logic isRotl;
	logic [10:0] match;

	//////////////////////////////
	// Instruction matches
	//////////////////////////////
	assign isRType = (op == cpuPkg::OP_RTYPE);

	// R-type needs the funct as well
	assign isAdd = isRType && (func == cpuPkg::FN_ADD);
	assign isSub = isRType && (func == cpuPkg::FN_SUB);
	assign isJr  = isRType && (func == cpuPkg::FN_JR);

	assign isOri  = (op == cpuPkg::OP_ORI);
	assign isLw   = (op == cpuPkg::OP_LW);
	assign isSw   = (op == cpuPkg::OP_SW);
	assign isBeq  = (op == cpuPkg::OP_BEQ);
	assign isLui  = (op == cpuPkg::OP_LUI);
	assign isJal  = (op == cpuPkg::OP_JAL);
	assign isJ    = (op == cpuPkg::OP_J);
	assign isRotl = (op == cpuPkg::OP_ROTL);

	assign match = {isAdd, isSub, isOri, isLw, isSw, isBeq, isLui, isJal, isJr, isJ, isRotl};

	//////////////////////////////
	// Control fields
	//////////////////////////////
	// Bit 1 picks $ra, bit 0 picks rd
	assign regDst[1] = isJal;
	assign regDst[0] = isAdd | isSub;

	assign regWriteEn = isAdd | isSub | isOri | isLw | isLui | isJal | isRotl;

	// Only address offsets are sign extended
	assign signExt = isLw | isSw;

	assign aluSrcImm = isOri | isLw | isSw | isLui | isRotl;

	assign aluOp[2] = isRotl;
	assign aluOp[1] = isOri;
	assign aluOp[0] = isSub;

	assign memWriteEn = isSw;

	// lui takes both bits, giving the upper immediate
	assign wbSel[1] = isLui | isJal;
	assign wbSel[0] = isLw | isLui;

	// jr sets both bits for the register target
	assign npcSel[1] = isBeq | isJr;
	assign npcSel[0] = isJal | isJr | isJ;

	// Decoded opcodes never overlap
	matchOneHot: assert property (@(match) $onehot0(match))
		else $error("controlUnit: several instruction matches %b", match);

endmodule

//--- rtl/nextPc.sv
`timescale 1ns/1ns

`include "cpu_params.svh"

module nextPc (
	input                  clk,
	input                  rstN,
	input  cpuPkg::npcSelT npcSel,
	input                  equal,
	input  logic [25:0]    jumpIndex,
	input  logic [15:0]    imm,
	input  cpuPkg::wordT   rsData,
	output cpuPkg::wordT   pc,
	output cpuPkg::wordT   pcPlus4
);

	cpuPkg::wordT jumpTarget;
	cpuPkg::wordT branchTarget;
	cpuPkg::wordT npc;

	assign pcPlus4 = pc + 32'd4;

	// Region of the following instruction
	assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

	// Word offset relative to the following instruction
	assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

	always_comb begin
		case (npcSel)
			cpuPkg::NPC_JUMP:   npc = jumpTarget;
			cpuPkg::NPC_BRANCH: npc = equal ? branchTarget : pcPlus4;
			cpuPkg::NPC_REG:    npc = rsData;
			default:            npc = pcPlus4;
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `CPU_RESET_PC;
		end else begin
			pc <= npc;
		end
	end

	// Only a register target can break alignment
	pcAligned: assert property (@(posedge clk) disable iff (!rstN)
		(npcSel != cpuPkg::NPC_REG && pc[1:0] == 2'b00) |=> pc[1:0] == 2'b00)
		else $error("nextPc: pc lost word alignment, pc=%h", pc);

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
	input                   clk,
	input                   rstN,
	input  cpuPkg::regAddrT rsAddr,
	input  cpuPkg::regAddrT rtAddr,
	output cpuPkg::wordT    rsData,
	output cpuPkg::wordT    rtData,
	input                   writeEn,
	input  cpuPkg::regAddrT writeAddr,
	input  cpuPkg::wordT    writeData
);

	cpuPkg::wordT regs [32];

	//////////////////////////////
	// Write port
	//////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	//////////////////////////////
	// Read ports
	//////////////////////////////
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	// A write, even one aimed at $0, leaves $0 reading zero
	zeroRegRs: assert property (@(posedge clk) disable iff (!rstN)
		writeEn |=> (rsAddr != '0 || rsData == '0))
		else $error("regFile: $0 read back %h on rs", rsData);

	zeroRegRt: assert property (@(posedge clk) disable iff (!rstN)
		writeEn |=> (rtAddr != '0 || rtData == '0))
		else $error("regFile: $0 read back %h on rt", rtData);

endmodule

//--- rtl/execUnit.sv
`timescale 1ns/1ns

module execUnit (
	input  cpuPkg::wordT  rsData,
	input  cpuPkg::wordT  rtData,
	input  logic [15:0]   imm,
	input                 signExt,
	input                 aluSrcImm,
	input  cpuPkg::aluOpT aluOp,
	output cpuPkg::wordT  aluResult,
	output logic          equal
);

	cpuPkg::wordT immExt;
	cpuPkg::wordT opB;
	logic [4:0]   rotAmount;
	logic [63:0]  rotWide;
	cpuPkg::wordT rotResult;

	//////////////////////////////
	// Operand B
	//////////////////////////////
	assign immExt = signExt ? {{16{imm[15]}}, imm} : {16'h0000, imm};

	assign opB = aluSrcImm ? immExt : rtData;

	//////////////////////////////
	// Rotate left
	//////////////////////////////
	// Shift a doubled copy, bits leaving the top wrap into the upper half
	assign rotAmount = opB[4:0];
	assign rotWide   = {rsData, rsData} << rotAmount;
	assign rotResult = rotWide[63:32];

	//////////////////////////////
	// ALU
	//////////////////////////////
	always_comb begin
		case (aluOp)
			cpuPkg::ALU_ADD:  aluResult = rsData + opB;
			cpuPkg::ALU_SUB:  aluResult = rsData - opB;
			cpuPkg::ALU_OR:   aluResult = rsData | opB;
			cpuPkg::ALU_ROTL: aluResult = rotResult;
			default:          aluResult = '0;
		endcase
	end

	// beq compares both registers, not operand B
	assign equal = (rsData == rtData);

endmodule

//--- rtl/dataMem.sv
`timescale 1ns/1ns

`include "cpu_params.svh"

module dataMem (
	input                clk,
	input  cpuPkg::wordT addr,
	input                writeEn,
	input  cpuPkg::wordT writeData,
	output cpuPkg::wordT readData
);

	cpuPkg::wordT mem [`DM_WORDS];

	logic [`DM_ADDR_BITS-1:0] wordIndex;

	// Word index from byte address, upper bits ignored
	assign wordIndex = addr[`DM_ADDR_BITS+1:2];

	// Start from a cleared memory
	initial begin
		for (int i = 0; i < `DM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[wordIndex] <= writeData;
		end
	end

	assign readData = mem[wordIndex];

endmodule

//--- rtl/cpuTop.sv
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpuTop (
	input                   clk,
	input                   rstN,
	input  cpuPkg::wordT    instr,
	output cpuPkg::wordT    pc,
	output logic            regWrite,
	output cpuPkg::regAddrT regAddr,
	output cpuPkg::wordT    regData,
	output logic            memWrite,
	output cpuPkg::wordT    memAddr,
	output cpuPkg::wordT    memData
);

	//////////////////////////////
	// Instruction fields
	//////////////////////////////
	cpuPkg::opcodeT  op;
	cpuPkg::funcT    func;
	cpuPkg::regAddrT rs;
	cpuPkg::regAddrT rt;
	cpuPkg::regAddrT rd;
	logic [15:0]     imm;
	logic [25:0]     jumpIndex;

	assign op        = instr[31:26];
	assign rs        = instr[25:21];
	assign rt        = instr[20:16];
	assign rd        = instr[15:11];
	assign func      = instr[5:0];
	assign imm       = instr[15:0];
	assign jumpIndex = instr[25:0];

	cpuPkg::regDstT regDst;
	logic           regWriteEn;
	logic           signExt;
	logic           aluSrcImm;
	cpuPkg::aluOpT  aluOp;
	logic           memWriteEn;
	cpuPkg::wbSelT  wbSel;
	cpuPkg::npcSelT npcSel;

	cpuPkg::wordT    rsData;
	cpuPkg::wordT    rtData;
	cpuPkg::wordT    aluResult;
	logic            equal;
	cpuPkg::wordT    pcPlus4;
	cpuPkg::wordT    readData;
	cpuPkg::regAddrT destAddr;
	cpuPkg::wordT    wbData;

	controlUnit controlUnit_i (.op(op), .func(func), .regDst(regDst),
		.regWriteEn(regWriteEn), .signExt(signExt), .aluSrcImm(aluSrcImm),
		.aluOp(aluOp), .memWriteEn(memWriteEn), .wbSel(wbSel), .npcSel(npcSel));

	nextPc nextPc_i (.clk(clk), .rstN(rstN), .npcSel(npcSel), .equal(equal),
		.jumpIndex(jumpIndex), .imm(imm), .rsData(rsData), .pc(pc), .pcPlus4(pcPlus4));

	regFile regFile_i (.clk(clk), .rstN(rstN), .rsAddr(rs), .rtAddr(rt),
		.rsData(rsData), .rtData(rtData), .writeEn(regWriteEn),
		.writeAddr(destAddr), .writeData(wbData));

	execUnit execUnit_i (.rsData(rsData), .rtData(rtData), .imm(imm),
		.signExt(signExt), .aluSrcImm(aluSrcImm), .aluOp(aluOp),
		.aluResult(aluResult), .equal(equal));

	dataMem dataMem_i (.clk(clk), .addr(aluResult), .writeEn(memWriteEn),
		.writeData(rtData), .readData(readData));

	//////////////////////////////
	// Write-back
	//////////////////////////////
	always_comb begin
		case (regDst)
			cpuPkg::DST_RD: destAddr = rd;
			cpuPkg::DST_RA: destAddr = `REG_LINK;
			default:        destAddr = rt;
		endcase
	end

	always_comb begin
		case (wbSel)
			cpuPkg::WB_MEM:   wbData = readData;
			cpuPkg::WB_LINK:  wbData = pcPlus4;
			cpuPkg::WB_UPPER: wbData = {imm, 16'h0000};
			default:          wbData = aluResult;
		endcase
	end

	// Retire trace of the current instruction
	assign regWrite = regWriteEn;
	assign regAddr  = destAddr;
	assign regData  = wbData;
	assign memWrite = memWriteEn;
	assign memAddr  = aluResult;
	assign memData  = rtData;

endmodule

//--- verification/cpuTb.sv
`timescale 1ns/1ns

`include "cpu_params.svh"

module cpuTb;

	localparam int CLK_PERIOD     = 100;
	localparam int DRIVE_DELAY    = 10;
	localparam int RESET_CYCLES   = 2;
	localparam int NUM_INSTR      = 400;
	// Reset, one cycle per instruction, and a small margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_INSTR + 18;

	logic            clk;
	logic            rstN;
	cpuPkg::wordT    instr;
	cpuPkg::wordT    pc;
	logic            regWrite;
	cpuPkg::regAddrT regAddr;
	cpuPkg::wordT    regData;
	logic            memWrite;
	cpuPkg::wordT    memAddr;
	cpuPkg::wordT    memData;

	// Reference model state and expected retire trace
	cpuPkg::wordT    modelPc;
	cpuPkg::wordT    modelRegs [32];
	cpuPkg::wordT    modelMem [`DM_WORDS];
	cpuPkg::wordT    expPc;
	logic            expRegWrite;
	cpuPkg::regAddrT expRegAddr;
	cpuPkg::wordT    expRegData;
	logic            expMemWrite;
	cpuPkg::wordT    expMemAddr;
	cpuPkg::wordT    expMemData;
	logic [31:0]     rngState;
	int              cycleCount;

	cpuTop cpuTop_i (.clk(clk), .rstN(rstN), .instr(instr), .pc(pc),
		.regWrite(regWrite), .regAddr(regAddr), .regData(regData),
		.memWrite(memWrite), .memAddr(memAddr), .memData(memData));

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] nextRandom();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// One bit at a time, top bit wraps to bit 0
	function automatic cpuPkg::wordT rotateLeft(input cpuPkg::wordT value,
		input logic [4:0] amount);
		cpuPkg::wordT result;
		result = value;
		for (int i = 0; i < amount; i++) begin
			result = {result[30:0], result[31]};
		end
		return result;
	endfunction

	function automatic logic isKnownOpcode(input cpuPkg::opcodeT op);
		case (op)
			cpuPkg::OP_RTYPE, cpuPkg::OP_J, cpuPkg::OP_JAL, cpuPkg::OP_BEQ,
			cpuPkg::OP_ORI, cpuPkg::OP_LUI, cpuPkg::OP_LW, cpuPkg::OP_SW,
			cpuPkg::OP_ROTL: return 1'b1;
			default:         return 1'b0;
		endcase
	endfunction

	task automatic stopOnFailure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("** Error [%s] expected %h, actual %h, time %0t", testName, expected,
			actual, $time);
		stopOnFailure();
	endtask

	// $0 shows on the trace but keeps reading zero in the model
	task automatic recordRegWrite(input cpuPkg::regAddrT addr, input cpuPkg::wordT value);
		expRegWrite = 1'b1;
		expRegAddr  = addr;
		expRegData  = value;
		if (addr != 5'd0) begin
			modelRegs[addr] = value;
		end
	endtask

	//////////////////////////////
	// Generator and model step
	//////////////////////////////
	task automatic stepModel();
		logic [31:0]     r1;
		logic [31:0]     r2;
		logic [31:0]     r3;
		cpuPkg::regAddrT rs;
		cpuPkg::regAddrT rt;
		cpuPkg::regAddrT rd;
		logic [15:0]     imm;
		cpuPkg::opcodeT  op;
		cpuPkg::wordT    word;
		cpuPkg::wordT    pcPlus4;
		cpuPkg::wordT    nextPcVal;
		int              kind;
		r1 = nextRandom();
		r2 = nextRandom();
		r3 = nextRandom();
		kind = int'(r1 % 32'd20);
		rs = r2[4:0] % 5'd31;
		rt = r2[9:5] % 5'd31;
		rd = r2[14:10] % 5'd31;
		imm = r2[31:16];
		pcPlus4 = modelPc + 32'd4;
		nextPcVal = pcPlus4;
		expPc = modelPc;
		expRegWrite = 1'b0;
		expRegAddr = '0;
		expRegData = '0;
		expMemWrite = 1'b0;
		expMemAddr = '0;
		expMemData = '0;
		case (kind)
			0, 1, 2: begin
				word = {cpuPkg::OP_RTYPE, rs, rt, rd, 5'd0, cpuPkg::FN_ADD};
				recordRegWrite(rd, modelRegs[rs] + modelRegs[rt]);
			end
			3, 4: begin
				word = {cpuPkg::OP_RTYPE, rs, rt, rd, 5'd0, cpuPkg::FN_SUB};
				recordRegWrite(rd, modelRegs[rs] - modelRegs[rt]);
			end
			5, 6: begin
				word = {cpuPkg::OP_ORI, rs, rt, imm};
				recordRegWrite(rt, modelRegs[rs] | {16'h0000, imm});
			end
			7, 8: begin
				// Sixteen word slots so loads hit earlier stores
				imm = {10'd0, r3[3:0], 2'b00};
				word = {cpuPkg::OP_LW, 5'd0, rt, imm};
				recordRegWrite(rt, modelMem[imm[`DM_ADDR_BITS+1:2]]);
			end
			9, 10: begin
				imm = {10'd0, r3[3:0], 2'b00};
				word = {cpuPkg::OP_SW, 5'd0, rt, imm};
				expMemWrite = 1'b1;
				expMemAddr = {16'h0000, imm};
				expMemData = modelRegs[rt];
				modelMem[imm[`DM_ADDR_BITS+1:2]] = modelRegs[rt];
			end
			11, 12: begin
				// Same register on both sides forces a taken branch
				if (r3[31]) begin
					rt = rs;
				end
				word = {cpuPkg::OP_BEQ, rs, rt, imm};
				if (modelRegs[rs] == modelRegs[rt]) begin
					nextPcVal = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};
				end
			end
			13: begin
				word = {cpuPkg::OP_LUI, 5'd0, rt, imm};
				recordRegWrite(rt, {imm, 16'h0000});
			end
			14: begin
				word = {cpuPkg::OP_JAL, r3[25:0]};
				recordRegWrite(`REG_LINK, pcPlus4);
				nextPcVal = {pcPlus4[31:28], r3[25:0], 2'b00};
			end
			15: begin
				// Scan for an aligned value, $0 ends the search
				rs = r3[30:26];
				while (modelRegs[rs][1:0] != 2'b00) begin
					rs = rs + 5'd1;
				end
				word = {cpuPkg::OP_RTYPE, rs, 15'd0, cpuPkg::FN_JR};
				nextPcVal = modelRegs[rs];
			end
			16: begin
				word = {cpuPkg::OP_J, r3[25:0]};
				nextPcVal = {pcPlus4[31:28], r3[25:0], 2'b00};
			end
			17, 18: begin
				word = {cpuPkg::OP_ROTL, rs, rt, imm};
				recordRegWrite(rt, rotateLeft(modelRegs[rs], imm[4:0]));
			end
			default: begin
				op = r3[31:26];
				while (isKnownOpcode(op)) begin
					op = op + 6'd1;
				end
				word = {op, r3[25:0]};
			end
		endcase
		instr = word;
		modelPc = nextPcVal;
	endtask

	//////////////////////////////
	// Checks
	//////////////////////////////
	// Sampled on the falling edge, midway between drive and retire
	resetPcCheck: assert property (@(negedge clk) !rstN |-> pc == `CPU_RESET_PC)
		else reportMismatch("resetPc", `CPU_RESET_PC, pc);

	pcCheck: assert property (@(negedge clk) disable iff (!rstN) pc == expPc)
		else reportMismatch("pc", expPc, pc);

	regWriteCheck: assert property (@(negedge clk) disable iff (!rstN)
		regWrite == expRegWrite)
		else reportMismatch("regWrite", expRegWrite, regWrite);

	regAddrCheck: assert property (@(negedge clk) disable iff (!rstN)
		expRegWrite |-> regAddr == expRegAddr)
		else reportMismatch("regAddr", expRegAddr, regAddr);

	regDataCheck: assert property (@(negedge clk) disable iff (!rstN)
		expRegWrite |-> regData == expRegData)
		else reportMismatch("regData", expRegData, regData);

	memWriteCheck: assert property (@(negedge clk) disable iff (!rstN)
		memWrite == expMemWrite)
		else reportMismatch("memWrite", expMemWrite, memWrite);

	memAddrCheck: assert property (@(negedge clk) disable iff (!rstN)
		expMemWrite |-> memAddr == expMemAddr)
		else reportMismatch("memAddr", expMemAddr, memAddr);

	memDataCheck: assert property (@(negedge clk) disable iff (!rstN)
		expMemWrite |-> memData == expMemData)
		else reportMismatch("memData", expMemData, memData);

	//////////////////////////////
	// Run control
	//////////////////////////////
	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the instruction stream did not finish within %0d cycles",
			TIMEOUT_CYCLES);
		stopOnFailure();
	end

	initial begin
		rstN = 1'b0;
		instr = '0;
		rngState = 32'd49;
		modelPc = `CPU_RESET_PC;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < `DM_WORDS; i++) begin
			modelMem[i] = '0;
		end
		expPc = modelPc;
		expRegWrite = 1'b0;
		expRegAddr = '0;
		expRegData = '0;
		expMemWrite = 1'b0;
		expMemAddr = '0;
		expMemData = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rstN = 1'b1;
		for (int n = 0; n < NUM_INSTR; n++) begin
			stepModel();
			@(posedge clk);
			#DRIVE_DELAY;
		end
		$display("NO ERRORS");
		$finish;
	end

endmodule

//--- files.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/nextPc.sv
rtl/regFile.sv
rtl/execUnit.sv
rtl/dataMem.sv
rtl/cpuTop.sv
verification/cpuTb.sv
